// ==== src/rv_consts.svh ====
// global widths and reset values of the rv64i execute slice
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// integer register width
`define RV_XLEN 64

// number of general purpose registers, x0 included
`define RV_REG_COUNT 32

// instruction word width, no compressed encodings
`define RV_ILEN 32

// value held in the write-back data register out of reset
`define RV_WB_RESET_DATA {`RV_XLEN{1'b0}}

// field positions shared by every major opcode
`define RV_OPC_LSB 0
`define RV_RD_LSB 7
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20

`endif

// ==== src/rv_types_pkg.sv ====
// data width types shared by decoder, register file and alu
`default_nettype none

`include "rv_consts.svh"

package rv_types_pkg;

	// register contents and alu results
	typedef logic [`RV_XLEN-1:0] xlen_t;

	// register index, wide enough for every gpr
	typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;

	// raw instruction word from upstream
	typedef logic [`RV_ILEN-1:0] instr_t;

	// shift amount, rv64 shifts use six bits
	typedef logic [$clog2(`RV_XLEN)-1:0] shamt_t;

endpackage

`default_nettype wire

// ==== src/rv_isa_pkg.sv ====
// rv64i opcode, funct field and internal alu operation encodings
`default_nettype none

package rv_isa_pkg;

	// major opcode, bits 6:0
	typedef logic [6:0] opcode_t;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;

	// funct3 groups, bits 14:12
	typedef logic [2:0] funct3_t;
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SR      = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// funct7 for register-register ops, bits 31:25
	typedef logic [6:0] funct7_t;
	localparam funct7_t F7_BASE = 7'b0000000;
	// sub and sra
	localparam funct7_t F7_ALT  = 7'b0100000;

	// upper funct6 of rv64 shift immediates, bits 31:26
	typedef logic [5:0] funct6_t;
	localparam funct6_t F6_BASE = 6'b000000;
	localparam funct6_t F6_SRAI = 6'b010000;

	// alu operation selected by the decoder
	typedef logic [3:0] alu_op_t;
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLL    = 4'd2;
	localparam alu_op_t ALU_SLT    = 4'd3;
	localparam alu_op_t ALU_SLTU   = 4'd4;
	localparam alu_op_t ALU_XOR    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_OR     = 4'd8;
	localparam alu_op_t ALU_AND    = 4'd9;
	// lui, operand b straight through
	localparam alu_op_t ALU_PASS_B = 4'd10;

endpackage

`default_nettype wire

// ==== src/instr_decoder.sv ====
// instruction decoder, splits an rv64i word into operands, immediate and alu operation
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module instr_decoder (
	input  rv_types_pkg::instr_t    instr,
	input  logic                    instr_valid,
	output rv_types_pkg::reg_addr_t rs1_addr,
	output rv_types_pkg::reg_addr_t rs2_addr,
	output rv_types_pkg::reg_addr_t rd_addr,
	output logic                    rs1_en,
	output logic                    rs2_en,
	output logic                    use_imm,
	output logic                    op_valid,
	output logic                    op_illegal,
	output rv_isa_pkg::alu_op_t     alu_op,
	output rv_types_pkg::xlen_t     imm
);

	import rv_types_pkg::*;
	import rv_isa_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	funct6_t funct6;
	logic    is_op;
	logic    is_op_imm;
	logic    is_lui;
	logic    base_ok;
	logic    legal;
	xlen_t   i_imm;
	xlen_t   u_imm;

	// fixed field positions
	assign opcode   = instr[`RV_OPC_LSB +: 7];
	assign rd_addr  = instr[`RV_RD_LSB +: $bits(reg_addr_t)];
	assign rs1_addr = instr[`RV_RS1_LSB +: $bits(reg_addr_t)];
	assign rs2_addr = instr[`RV_RS2_LSB +: $bits(reg_addr_t)];
	assign funct3   = instr[14:12];
	assign funct7   = instr[31:25];
	assign funct6   = instr[31:26];

	assign is_op     = (opcode == OPC_OP);
	assign is_op_imm = (opcode == OPC_OP_IMM);
	assign is_lui    = (opcode == OPC_LUI);

	// i-type sign extended, u-type placed at bit 12
	assign i_imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
	assign u_imm = {{(`RV_XLEN-32){instr[31]}}, instr[31:12], 12'b0};

	assign rs1_en  = is_op | is_op_imm;
	assign rs2_en  = is_op;
	assign use_imm = is_op_imm | is_lui;
	assign imm     = is_lui ? u_imm : i_imm;

	// funct7 only matters for register-register ops
	assign base_ok = is_op_imm || (funct7 == F7_BASE);

	always_comb begin
		alu_op = ALU_ADD;
		legal  = 1'b0;
		if (is_lui) begin
			alu_op = ALU_PASS_B;
			legal  = 1'b1;
		end else if (is_op || is_op_imm) begin
			case (funct3)
				F3_ADD_SUB: begin
					// no subi, funct7 alt only selects sub on op
					alu_op = (is_op && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
					legal  = base_ok || (funct7 == F7_ALT);
				end
				F3_SLL: begin
					alu_op = ALU_SLL;
					legal  = is_op ? (funct7 == F7_BASE) : (funct6 == F6_BASE);
				end
				F3_SLT: begin
					alu_op = ALU_SLT;
					legal  = base_ok;
				end
				F3_SLTU: begin
					alu_op = ALU_SLTU;
					legal  = base_ok;
				end
				F3_XOR: begin
					alu_op = ALU_XOR;
					legal  = base_ok;
				end
				F3_SR: begin
					// srl/sra from funct7, srli/srai from the upper six bits
					if (is_op) begin
						alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						legal  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
					end else begin
						alu_op = (funct6 == F6_SRAI) ? ALU_SRA : ALU_SRL;
						legal  = (funct6 == F6_BASE) || (funct6 == F6_SRAI);
					end
				end
				F3_OR: begin
					alu_op = ALU_OR;
					legal  = base_ok;
				end
				F3_AND: begin
					alu_op = ALU_AND;
					legal  = base_ok;
				end
			endcase
		end
	end

	// one of the two strobes per accepted word
	always_comb begin
		op_valid   = instr_valid && legal;
		op_illegal = instr_valid && !legal;
	end

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
// 32 x 64 gpr file, x0 tied to zero, two combinational read ports with write forwarding
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module regfile (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    we,
	input  rv_types_pkg::reg_addr_t waddr,
	input  rv_types_pkg::xlen_t     wdata,
	input  rv_types_pkg::reg_addr_t raddr1,
	input  rv_types_pkg::reg_addr_t raddr2,
	input  logic                    re1,
	input  logic                    re2,
	output rv_types_pkg::xlen_t     rdata1,
	output rv_types_pkg::xlen_t     rdata2
);

	import rv_types_pkg::*;

	xlen_t regs [`RV_REG_COUNT];
	logic  wr_ok;
	logic  fwd1;
	logic  fwd2;

	// writes to x0 dropped here and nowhere else
	assign wr_ok = we && (waddr != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[waddr] <= wdata;
		end
	end

	// write-back in the same cycle bypasses the array
	assign fwd1 = wr_ok && (waddr == raddr1);
	assign fwd2 = wr_ok && (waddr == raddr2);

	// disabled port or reset gives zero
	assign rdata1 = (!reset && re1) ? (fwd1 ? wdata : regs[raddr1]) : '0;
	assign rdata2 = (!reset && re2) ? (fwd2 ? wdata : regs[raddr2]) : '0;

	// x0 stays zero on both ports, forwarding included
	assert property (@(posedge clk) (raddr1 == '0) |-> (rdata1 == '0));
	assert property (@(posedge clk) (raddr2 == '0) |-> (rdata2 == '0));

endmodule

`default_nettype wire

// ==== src/int_alu.sv ====
// integer alu with registered write-back stage, one cycle from operands to pulse
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module int_alu (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    op_valid,
	input  logic                    op_illegal,
	input  rv_isa_pkg::alu_op_t     alu_op,
	input  rv_types_pkg::xlen_t     rs1_data,
	input  rv_types_pkg::xlen_t     rs2_data,
	input  rv_types_pkg::xlen_t     imm,
	input  logic                    use_imm,
	input  rv_types_pkg::reg_addr_t rd_addr,
	output logic                    wb_valid,
	output rv_types_pkg::reg_addr_t wb_rd,
	output rv_types_pkg::xlen_t     wb_data,
	output logic                    illegal
);

	import rv_types_pkg::*;
	import rv_isa_pkg::*;

	xlen_t  op_a;
	xlen_t  op_b;
	shamt_t shamt;
	xlen_t  result;

	assign op_a = rs1_data;
	// immediate for op-imm and lui, rs2 otherwise
	assign op_b = use_imm ? imm : rs2_data;
	// only the low six bits shift on rv64
	assign shamt = op_b[$bits(shamt_t)-1:0];

	always_comb begin
		result = '0;
		case (alu_op)
			ALU_ADD:    result = op_a + op_b;
			ALU_SUB:    result = op_a - op_b;
			ALU_SLL:    result = op_a << shamt;
			ALU_SLT:    result[0] = ($signed(op_a) < $signed(op_b));
			ALU_SLTU:   result[0] = (op_a < op_b);
			ALU_XOR:    result = op_a ^ op_b;
			ALU_SRL:    result = op_a >> shamt;
			ALU_SRA:    result = $signed(op_a) >>> shamt;
			ALU_OR:     result = op_a | op_b;
			ALU_AND:    result = op_a & op_b;
			ALU_PASS_B: result = op_b;
			default:    result = '0;
		endcase
	end

	// write-back stage, pulses drop without a new word
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			illegal  <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= `RV_WB_RESET_DATA;
		end else begin
			wb_valid <= op_valid;
			illegal  <= op_illegal;
			if (op_valid) begin
				wb_rd   <= rd_addr;
				wb_data <= result;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) !(wb_valid && illegal));

endmodule

`default_nettype wire

// ==== src/int_exec_top.sv ====
// rv64i execute slice top, decoder feeding register file and alu
`timescale 1ns/1ps
`default_nettype none

module int_exec_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    instr_valid,
	input  rv_types_pkg::instr_t    instr,
	output logic                    wb_valid,
	output rv_types_pkg::reg_addr_t wb_rd,
	output rv_types_pkg::xlen_t     wb_data,
	output logic                    illegal
);

	import rv_types_pkg::*;
	import rv_isa_pkg::*;

	// decode to register file
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	logic      rs1_en;
	logic      rs2_en;

	// decode to alu
	reg_addr_t rd_addr;
	alu_op_t   alu_op;
	xlen_t     imm;
	logic      use_imm;
	logic      op_valid;
	logic      op_illegal;

	// operands
	xlen_t     rs1_data;
	xlen_t     rs2_data;

	instr_decoder u_decoder (
		.instr       (instr),
		.instr_valid (instr_valid),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rd_addr     (rd_addr),
		.rs1_en      (rs1_en),
		.rs2_en      (rs2_en),
		.use_imm     (use_imm),
		.op_valid    (op_valid),
		.op_illegal  (op_illegal),
		.alu_op      (alu_op),
		.imm         (imm)
	);

	// write port driven from the alu write-back stage
	regfile u_regfile (
		.clk    (clk),
		.reset  (reset),
		.we     (wb_valid),
		.waddr  (wb_rd),
		.wdata  (wb_data),
		.raddr1 (rs1_addr),
		.raddr2 (rs2_addr),
		.re1    (rs1_en),
		.re2    (rs2_en),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	int_alu u_alu (
		.clk        (clk),
		.reset      (reset),
		.op_valid   (op_valid),
		.op_illegal (op_illegal),
		.alu_op     (alu_op),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.imm        (imm),
		.use_imm    (use_imm),
		.rd_addr    (rd_addr),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.illegal    (illegal)
	);

endmodule

`default_nettype wire

// ==== verif/exec_checker.sv ====
// reference model of the execute slice, predicts and compares every write-back and illegal pulse
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module exec_checker (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    instr_valid,
	input  rv_types_pkg::instr_t    instr,
	input  logic                    wb_valid,
	input  rv_types_pkg::reg_addr_t wb_rd,
	input  rv_types_pkg::xlen_t     wb_data,
	input  logic                    illegal,
	output int                      error_count,
	output int                      check_count,
	output int                      pulse_count
);

	import rv_types_pkg::*;
	import rv_isa_pkg::*;

	// architectural state as the isa sees it
	xlen_t     model_regs [`RV_REG_COUNT];
	logic      armed = 1'b0;
	logic      exp_valid = 1'b0;
	logic      exp_illegal = 1'b0;
	logic      check_data = 1'b0;
	reg_addr_t exp_rd = '0;
	xlen_t     exp_data = '0;
	int        errors = 0;
	int        checks = 0;
	int        pulses = 0;

	assign error_count = errors;
	assign check_count = checks;
	assign pulse_count = pulses;

	task automatic compare_value(input string name, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// one accepted word, sets the expected outcome and updates the model
	task automatic predict(input instr_t word);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		xlen_t      a;
		xlen_t      b;
		xlen_t      sra_val;
		xlen_t      res;
		shamt_t     sh;
		logic       ok;
		logic       alt;
		opc = word[6:0];
		f3  = word[14:12];
		f7  = word[31:25];
		a   = model_regs[word[19:15]];
		b   = '0;
		ok  = 1'b1;
		alt = 1'b0;
		res = '0;
		if (opc == OPC_LUI) begin
			res = {{(`RV_XLEN-32){word[31]}}, word[31:12], 12'h000};
		end else if (opc == OPC_OP) begin
			b   = model_regs[word[24:20]];
			alt = (f7 == F7_ALT);
			// alt pattern only for sub and sra
			ok  = (f7 == F7_BASE) || (alt && (f3 == F3_ADD_SUB || f3 == F3_SR));
		end else if (opc == OPC_OP_IMM) begin
			b   = {{(`RV_XLEN-12){word[31]}}, word[31:20]};
			// srai is the only shift immediate with bit 30 set
			alt = (f3 == F3_SR) && word[30];
			if (f3 == F3_SLL) begin
				ok = (word[31:26] == 6'b000000);
			end
			if (f3 == F3_SR) begin
				ok = (word[31:26] == 6'b000000) || (word[31:26] == 6'b010000);
			end
		end else begin
			ok = 1'b0;
		end
		sh      = b[5:0];
		sra_val = $signed(a) >>> sh;
		if (opc != OPC_LUI) begin
			case (f3)
				3'b000:  res = alt ? a - b : a + b;
				3'b001:  res = a << sh;
				3'b010:  res = xlen_t'($signed(a) < $signed(b));
				3'b011:  res = xlen_t'(a < b);
				3'b100:  res = a ^ b;
				3'b101:  res = alt ? sra_val : a >> sh;
				3'b110:  res = a | b;
				default: res = a & b;
			endcase
		end
		exp_valid   = ok;
		exp_illegal = !ok;
		check_data  = ok;
		if (ok) begin
			exp_rd   = word[11:7];
			exp_data = res;
		end
		// x0 keeps zero, the pulse still carries the data
		if (ok && word[11:7] != '0) begin
			model_regs[word[11:7]] = res;
		end
	endtask

	// inputs sampled before the testbench updates them at this edge
	always @(posedge clk) begin
		armed       = 1'b1;
		exp_valid   = 1'b0;
		exp_illegal = 1'b0;
		check_data  = 1'b0;
		if (reset) begin
			for (int i = 0; i < `RV_REG_COUNT; i++) begin
				model_regs[i] = '0;
			end
			exp_rd     = '0;
			exp_data   = '0;
			check_data = 1'b1;
		end else if (instr_valid) begin
			predict(instr);
		end
	end

	// outputs settled mid cycle
	always @(negedge clk) begin
		if (armed) begin
			compare_value("wb_valid", xlen_t'(wb_valid), xlen_t'(exp_valid));
			compare_value("illegal", xlen_t'(illegal), xlen_t'(exp_illegal));
			if (check_data) begin
				compare_value("wb_rd", xlen_t'(wb_rd), xlen_t'(exp_rd));
				compare_value("wb_data", wb_data, exp_data);
			end
			if (wb_valid === 1'b1 && illegal === 1'b1) begin
				errors++;
				$display("wb_valid and illegal were both high at %0t", $time);
			end
			if (wb_valid === 1'b1 || illegal === 1'b1) begin
				pulses++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/int_exec_tb.sv ====
// testbench for the rv64i execute slice, random legal and illegal instruction stream
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module int_exec_tb;

	import rv_types_pkg::*;
	import rv_isa_pkg::*;

	localparam int NUM_RANDOM  = 400;
	localparam int DRAIN_LIMIT = 20;

	logic        clk;
	logic        reset;
	logic        instr_valid;
	instr_t      instr;
	logic        wb_valid;
	reg_addr_t   wb_rd;
	xlen_t       wb_data;
	logic        illegal;
	int          error_count;
	int          check_count;
	int          pulse_count;
	int          issued;
	logic [31:0] lfsr_state;

	int_exec_top dut_i (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.illegal     (illegal)
	);

	exec_checker checker_i (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.illegal     (illegal),
		.error_count (error_count),
		.check_count (check_count),
		.pulse_count (pulse_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// galois lfsr x^32+x^22+x^2+x+1, one step per bit taken
	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] val;
		logic        lsb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lsb        = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			val = {val[30:0], lsb};
		end
		return val;
	endfunction

	// encodings the decoder has to refuse
	function automatic instr_t illegal_instr(input reg_addr_t rd, input reg_addr_t rs1,
			input reg_addr_t rs2, input logic [2:0] f3);
		logic [2:0] alt_f3;
		instr_t     word;
		case (2'(draw_bits(2)))
			// load opcode, not part of the slice
			2'd0: word = {12'(draw_bits(12)), rs1, f3, rd, 7'b0000011};
			// funct7 with bit 25 set
			2'd1: word = {6'(draw_bits(6)), 1'b1, rs2, rs1, f3, rd, OPC_OP};
			// shift immediate, funct6 with bit 26 set
			2'd2: word = {5'(draw_bits(5)), 1'b1, 6'(draw_bits(6)), rs1, F3_SR, rd, OPC_OP_IMM};
			default: begin
				alt_f3 = (f3 == F3_ADD_SUB || f3 == F3_SR) ? f3 + 3'd1 : f3;
				word   = {F7_ALT, rs2, rs1, alt_f3, rd, OPC_OP};
			end
		endcase
		return word;
	endfunction

	task automatic build_instr(output logic valid, output instr_t word);
		logic [2:0]  kind;
		logic [2:0]  f3;
		logic [11:0] imm12;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		kind  = 3'(draw_bits(3));
		// x0 to x7 only, so back to back dependencies are common
		rd    = reg_addr_t'(draw_bits(3));
		rs1   = reg_addr_t'(draw_bits(3));
		rs2   = reg_addr_t'(draw_bits(3));
		f3    = 3'(draw_bits(3));
		imm12 = 12'(draw_bits(12));
		valid = 1'b1;
		case (kind)
			// idle with garbage on the bus
			3'd0: begin
				valid = 1'b0;
				word  = instr_t'(draw_bits(32));
			end
			3'd1, 3'd2: begin
				if ((f3 == F3_ADD_SUB || f3 == F3_SR) && draw_bits(1) != 0) begin
					word = {F7_ALT, rs2, rs1, f3, rd, OPC_OP};
				end else begin
					word = {F7_BASE, rs2, rs1, f3, rd, OPC_OP};
				end
			end
			3'd3, 3'd4, 3'd7: begin
				if (f3 == F3_SLL) begin
					imm12 = {F6_BASE, imm12[5:0]};
				end else if (f3 == F3_SR) begin
					imm12 = {(draw_bits(1) != 0) ? F6_SRAI : F6_BASE, imm12[5:0]};
				end
				word = {imm12, rs1, f3, rd, OPC_OP_IMM};
			end
			3'd5: word = {20'(draw_bits(20)), rd, OPC_LUI};
			default: word = illegal_instr(rd, rs1, rs2, f3);
		endcase
	endtask

	initial begin
		instr_t word;
		logic   valid;
		logic   timed_out;
		int     wait_cycles;
		lfsr_state  = 32'd94252;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		issued      = 0;
		wait_cycles = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		// addi xn, xn, 0 over the whole file, all zero after reset
		for (int n = 0; n < `RV_REG_COUNT; n++) begin
			@(posedge clk);
			instr_valid <= 1'b1;
			instr       <= {12'd0, reg_addr_t'(n), F3_ADD_SUB, reg_addr_t'(n), OPC_OP_IMM};
			issued++;
		end
		for (int k = 0; k < NUM_RANDOM; k++) begin
			build_instr(valid, word);
			@(posedge clk);
			instr_valid <= valid;
			instr       <= word;
			if (valid) begin
				issued++;
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		instr       <= '0;
		// drain the last write-back
		while (pulse_count < issued && wait_cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			wait_cycles++;
		end
		timed_out = (pulse_count < issued);
		if (timed_out) begin
			$display("timeout: %0d of %0d pulses seen after the last instruction",
				pulse_count, issued);
		end else begin
			// a few idle cycles, no stray pulse
			repeat (3) @(posedge clk);
		end
		$display("errors %0d, checks %0d, pulses %0d of %0d instructions",
			error_count, check_count, pulse_count, issued);
		if (!timed_out && error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/rv_types_pkg.sv
src/rv_isa_pkg.sv
src/instr_decoder.sv
src/regfile.sv
src/int_alu.sv
src/int_exec_top.sv
verif/exec_checker.sv
verif/int_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the execute slice testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f sources.f --top-module int_exec_tb -o int_exec_sim

output=$(./obj_dir/int_exec_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1
